// File: filelist.f
+incdir+common
+incdir+bench
common/pin_ctrl_pkg.sv
common/cmd_bus_if.sv
pin_channel/pin_channel.sv
hw/time_base.sv
hw/sample_collector.sv
hw/bus_fabric.sv
hw/pin_ctrl_top.sv
bench/pin_ctrl_tb.sv

// File: bench/pin_ctrl_tb_table.svh
`ifndef PIN_CTRL_TB_TABLE_SVH
`define PIN_CTRL_TB_TABLE_SVH

// Columns are kind, address (or pin, mask, channel), data, expected value

localparam int NUM_ROWS = 48;

localparam logic [83:0] TABLE [0:NUM_ROWS-1] = '{
  // Register readback
  {K_RD,     16'h0108, 32'd0,          32'd1},
  {K_RD,     16'h0208, 32'd0,          32'd2},
  {K_RD,     16'h0308, 32'd0,          32'd3},
  {K_RD,     16'h0408, 32'd0,          32'd4},
  {K_WR,     16'h0209, 32'h12345A5A,   32'd0},
  {K_RD,     16'h0209, 32'd0,          32'h5A5A},
  {K_RD,     16'h0508, 32'd0,          32'd0},   // No block 5
  // Const output gated by the time base
  {K_WR,     16'h0102, 32'd40,         32'd0},
  {K_WR,     16'h0103, 32'd2,          32'd0},
  {K_WAIT,   16'h0000, 32'd5,          32'd0},
  {K_PIN,    16'd0,    32'd0,          32'd0},
  {K_WR,     16'h0000, 32'd1,          32'd0},
  {K_WAIT,   16'h0000, 32'd4,          32'd0},
  {K_PIN,    16'd0,    32'd0,          32'd1},
  {K_WAIT,   16'h0000, 32'd45,         32'd0},
  {K_RD,     16'h000A, 32'd1,          32'd41},
  {K_PIN,    16'd0,    32'd0,          32'd0},
  // Square wave on channel 2
  {K_WR,     16'h0201, 32'h10000000,   32'd0},
  {K_WR,     16'h0202, 32'd0,          32'd0},
  {K_WR,     16'h0203, 32'd3,          32'd0},
  {K_WAIT,   16'h0000, 32'd4,          32'd0},
  {K_EDGES,  16'd1,    32'd64,         32'd8},
  {K_WR,     16'h0203, 32'd5,          32'd0},
  {K_WAIT,   16'h0000, 32'd4,          32'd0},
  {K_PIN,    16'd1,    32'd0,          32'd0},
  // Stream on channel 3, then stop it
  {K_WR,     16'h0304, 32'd8,          32'd0},
  {K_WR,     16'h0303, 32'd4,          32'd0},
  {K_STREAM, 16'h0004, 32'd32,         32'd6},
  {K_WR,     16'h0303, 32'd5,          32'd0},
  {K_WAIT,   16'h0000, 32'd20,         32'd0},
  {K_MARK,   16'h0000, 32'd0,          32'd0},
  {K_WAIT,   16'h0000, 32'd40,         32'd0},
  {K_QUIET,  16'd3,    32'd0,          32'd0},
  {K_RD,     16'h0307, 32'd2,          32'd0},
  {K_RD,     16'h0307, 32'd0,          32'd24},  // One sample every 8 cycles until the reset
  // Two channels streaming at rates 8 and 16
  {K_WR,     16'h0000, 32'd2,          32'd0},
  {K_WR,     16'h0000, 32'd3,          32'd0},
  {K_WR,     16'h0104, 32'd8,          32'd0},
  {K_WR,     16'h0404, 32'd16,         32'd0},
  {K_WR,     16'h0103, 32'd4,          32'd0},
  {K_WR,     16'h0403, 32'd4,          32'd0},
  {K_WR,     16'h0000, 32'd1,          32'd0},
  {K_WAIT,   16'h0000, 32'd10,         32'd0},
  {K_MARK,   16'h0000, 32'd0,          32'd0},
  {K_WAIT,   16'h0000, 32'd160,        32'd0},
  {K_RATIO,  16'd1,    32'd4,          32'd2},
  {K_WR,     16'h0103, 32'd5,          32'd0},
  {K_RD,     16'h000B, 32'd0,          32'd0}
};

`endif

// File: bench/pin_ctrl_tb.sv
`timescale 1ns/100ps
`include "pin_ctrl_config.svh"

module pin_ctrl_tb;

  localparam int N = `PIN_NUM_PINS;
  localparam int HIST_W = 2 * N + 4;  // Cycles that may pass between a sample and its report

  // Row kinds of the stimulus table
  localparam logic [3:0] K_WR     = 4'd0;
  localparam logic [3:0] K_RD     = 4'd1;  // Data 0 exact, 1 at least, 2 last reported count
  localparam logic [3:0] K_WAIT   = 4'd2;
  localparam logic [3:0] K_PIN    = 4'd3;
  localparam logic [3:0] K_EDGES  = 4'd4;
  localparam logic [3:0] K_STREAM = 4'd5;
  localparam logic [3:0] K_MARK   = 4'd6;
  localparam logic [3:0] K_QUIET  = 4'd7;
  localparam logic [3:0] K_RATIO  = 4'd8;

  `include "pin_ctrl_tb_table.svh"

  localparam int LIMIT = NUM_ROWS * 64 + 500;

  logic        clk;
  logic        reset;
  logic        bus_wr;
  logic        bus_rd;
  logic [15:0] bus_addr;
  logic [31:0] bus_wdata;
  logic [15:0] bus_rdata;
  wire  [N-1:0] pins;
  logic        sample_valid;
  logic [7:0]  sample_chan;
  logic [31:0] sample_word;

  logic [N-1:0] drv_en;
  logic [N-1:0] drv_lvl;
  logic [N-1:0] hist [0:LIMIT];  // Pin level seen by the DUT at each edge
  logic [15:0]  lfsr;
  int           cyc;
  int           rep_cnt  [0:8];
  int           mark_cnt [0:8];
  int           last_rep [0:8];

  pin_ctrl_top DUT (
    .clk          (clk),
    .reset        (reset),
    .bus_wr       (bus_wr),
    .bus_rd       (bus_rd),
    .bus_addr     (bus_addr),
    .bus_wdata    (bus_wdata),
    .bus_rdata    (bus_rdata),
    .pins         (pins),
    .sample_valid (sample_valid),
    .sample_chan  (sample_chan),
    .sample_word  (sample_word)
  );

  always #2 clk = ~clk;

  // Strong drivers for stream tests, weak pull-down otherwise
  for (genvar i = 0; i < N; i++) begin : g_drv
    assign pins[i] = drv_en[i] ? drv_lvl[i] : 1'bz;
  end
  assign (weak0, weak1) pins = '0;

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  endtask

  // ----------------------------------------
  // Bus access
  // ----------------------------------------
  task automatic write_reg(input logic [15:0] a, input logic [31:0] d);
    @(posedge clk);
    bus_wr    <= 1'b1;
    bus_addr  <= a;
    bus_wdata <= d;
    @(posedge clk);
    bus_wr <= 1'b0;
  endtask

  task automatic read_reg(input logic [15:0] a, output logic [15:0] d);
    @(posedge clk);
    bus_rd   <= 1'b1;
    bus_addr <= a;
    @(posedge clk);
    bus_rd <= 1'b0;
    repeat (2) @(posedge clk);  // Fabric stage, then block stage
    d = bus_rdata;
  endtask

  task automatic drive_stream(input logic [N-1:0] mask, input int hold, input int levels);
    @(posedge clk);
    drv_en <= drv_en | mask;
    for (int l = 0; l < levels; l++) begin
      for (int p = 0; p < N; p++) begin
        if (mask[p]) begin
          lfsr = lfsr_step(lfsr);
          drv_lvl[p] <= lfsr[0];
        end
      end
      repeat (hold) @(posedge clk);
    end
    drv_en <= drv_en & ~mask;
  endtask

  task automatic count_edges(input int p, input int cycles, input int exp);
    logic prev;
    int   n;
    n = 0;
    @(posedge clk);
    prev = pins[p];
    repeat (cycles) begin
      @(posedge clk);
      if (pins[p] !== prev)
        n++;
      prev = pins[p];
    end
    check("square_edges_in_range", (n + 1 >= exp) && (n <= exp + 1), 1);
  endtask

  task automatic apply_row(input logic [83:0] row);
    logic [3:0]  kind;
    logic [15:0] a;
    logic [31:0] d;
    logic [31:0] e;
    logic [15:0] rdata;
    int          na;
    int          nb;
    {kind, a, d, e} = row;
    case (kind)
      K_WR:   write_reg(a, d);
      K_RD: begin
        read_reg(a, rdata);
        if (d == 1)
          check("bus_rdata_at_least", rdata >= e[15:0], 1);
        else if (d == 2)
          check("bus_rdata_sample_cnt", rdata, last_rep[a[15:8]]);
        else
          check("bus_rdata", rdata, e);
      end
      K_WAIT: repeat (d) @(posedge clk);
      K_PIN: begin
        @(posedge clk);
        check("pins", pins[a], e);
      end
      K_EDGES:  count_edges(a, d, e);
      K_STREAM: drive_stream(a[N-1:0], d, e);
      K_MARK: begin
        @(posedge clk);
        mark_cnt = rep_cnt;
      end
      K_QUIET: begin
        @(posedge clk);
        check("reports_after_reset", rep_cnt[a] - mark_cnt[a], 0);
      end
      K_RATIO: begin
        @(posedge clk);
        na = rep_cnt[a] - mark_cnt[a];
        nb = rep_cnt[d] - mark_cnt[d];
        check("rate_ratio_ok", (nb > 0) && (na >= e * (nb - 1)) && (na <= e * (nb + 1)), 1);
      end
      default: begin
        $display("The stimulus table holds a row of unknown kind %0d", kind);
        $display("Simulation finished: FAIL");
        $fatal(1);
      end
    endcase
  endtask

  // ----------------------------------------
  // Sample monitor and timeout
  // ----------------------------------------
  always @(posedge clk) begin : sample_monitor
    int   ch;
    logic stable;
    logic lvl;
    if (!reset && sample_valid) begin
      ch = sample_chan;
      check("sample_chan_in_range", (ch >= 1) && (ch <= N), 1);
      check("sample_tag", sample_word[15:1], `PIN_SAMPLE_TAG);
      check("sample_cnt_increasing", sample_word[31:16] > last_rep[ch], 1);
      stable = (cyc > HIST_W);
      lvl = stable ? hist[cyc-1][ch-1] : 1'b0;
      for (int k = 1; k <= HIST_W; k++) begin
        if (stable && (hist[cyc-k][ch-1] !== lvl))
          stable = 1'b0;  // Level changed near the sample, value is ambiguous
      end
      if (stable)
        check("sample_value", sample_word[0], lvl);
      rep_cnt[ch]  <= rep_cnt[ch] + 1;
      last_rep[ch] <= sample_word[31:16];
    end
  end

  always @(posedge clk) begin
    hist[cyc] <= drv_en & drv_lvl;
    cyc <= cyc + 1;
    if (cyc >= LIMIT) begin
      $display("Timeout: the test table did not finish within %0d cycles", LIMIT);
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  end

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    bus_wr    = 1'b0;
    bus_rd    = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    drv_en    = '0;
    drv_lvl   = '0;
    lfsr      = 16'd17378;
    cyc       = 0;
    for (int i = 0; i <= 8; i++) begin
      rep_cnt[i]  = 0;
      mark_cnt[i] = 0;
      last_rep[i] = 0;
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    for (int r = 0; r < NUM_ROWS; r++)
      apply_row(TABLE[r]);
    repeat (5) @(posedge clk);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: hw/pin_ctrl_top.sv
`timescale 1ns/100ps
`include "pin_ctrl_config.svh"

module pin_ctrl_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    bus_wr,
  input  logic                    bus_rd,
  input  logic [`PIN_ADDR_W-1:0]  bus_addr,
  input  logic [`PIN_WDATA_W-1:0] bus_wdata,
  output logic [`PIN_RDATA_W-1:0] bus_rdata,
  inout  wire  [`PIN_NUM_PINS-1:0] pins,
  output logic                    sample_valid,
  output logic [7:0]              sample_chan,
  output logic [31:0]             sample_word
);

  cmd_bus_if bus [0:`PIN_NUM_PINS] ();  // Index 0 is the time base

  logic [31:0] current_time;
  logic        sel_valid;
  logic [7:0]  sel_chan;
  logic [31:0] chan_words [1:`PIN_NUM_PINS];

  bus_fabric u_fabric (
    .clk       (clk),
    .reset     (reset),
    .bus_wr    (bus_wr),
    .bus_rd    (bus_rd),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_rdata (bus_rdata),
    .bus       (bus)
  );

  time_base u_time (
    .clk          (clk),
    .reset        (reset),
    .bus          (bus[0]),
    .current_time (current_time)
  );

  // ----------------------------------------
  // Pin channels, block numbers 1 to N
  // ----------------------------------------
  for (genvar g = 0; g < `PIN_NUM_PINS; g++) begin : g_chan
    pin_channel #(
      .POSITION (g + 1)
    ) u_chan (
      .clk          (clk),
      .reset        (reset),
      .current_time (current_time),
      .bus          (bus[g+1]),
      .pin          (pins[g]),
      .sel_valid    (sel_valid),
      .sel_chan     (sel_chan),
      .sample_word  (chan_words[g+1])
    );
  end

  sample_collector u_collect (
    .clk          (clk),
    .reset        (reset),
    .chan_words   (chan_words),
    .sel_valid    (sel_valid),
    .sel_chan     (sel_chan),
    .sample_valid (sample_valid),
    .sample_chan  (sample_chan),
    .sample_word  (sample_word)
  );

endmodule

// File: hw/bus_fabric.sv
`timescale 1ns/100ps
`include "pin_ctrl_config.svh"

module bus_fabric (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    bus_wr,
  input  logic                    bus_rd,
  input  logic [`PIN_ADDR_W-1:0]  bus_addr,
  input  logic [`PIN_WDATA_W-1:0] bus_wdata,
  output logic [`PIN_RDATA_W-1:0] bus_rdata,
  cmd_bus_if.source               bus [0:`PIN_NUM_PINS]
);

  logic                    wr_q;
  logic                    rd_q;
  logic [`PIN_ADDR_W-1:0]  addr_q;
  logic [`PIN_WDATA_W-1:0] wdata_q;
  logic [`PIN_RDATA_W-1:0] rd_chain [0:`PIN_NUM_PINS+1];

  // Host side register stage
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_q <= 1'b0;
      rd_q <= 1'b0;
    end else begin
      wr_q <= bus_wr;
      rd_q <= bus_rd;
    end
  end

  always_ff @(posedge clk) begin
    addr_q  <= bus_addr;
    wdata_q <= bus_wdata;
  end

  // ----------------------------------------
  // Broadcast and read combine
  // ----------------------------------------
  assign rd_chain[0] = '0;

  for (genvar g = 0; g <= `PIN_NUM_PINS; g++) begin : g_block
    assign bus[g].wr    = wr_q;
    assign bus[g].rd    = rd_q;
    assign bus[g].addr  = addr_q;
    assign bus[g].wdata = wdata_q;
    assign rd_chain[g+1] = rd_chain[g] | bus[g].rdata;
  end

  assign bus_rdata = rd_chain[`PIN_NUM_PINS+1];  // Block outputs are registers already

endmodule

// File: hw/sample_collector.sv
`timescale 1ns/100ps
`include "pin_ctrl_config.svh"

module sample_collector (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] chan_words [1:`PIN_NUM_PINS],
  output logic        sel_valid,
  output logic [7:0]  sel_chan,
  output logic        sample_valid,
  output logic [7:0]  sample_chan,
  output logic [31:0] sample_word
);

  logic [15:0] last_cnt [1:`PIN_NUM_PINS];  // Count last reported per channel
  logic [7:0]  chan_d;                      // Channel whose word arrives now
  logic        valid_d;
  logic [31:0] word_or;
  logic        new_sample;

  // ----------------------------------------
  // Scan pointer, one channel per cycle
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      sel_valid <= 1'b0;
      sel_chan  <= 8'(`PIN_NUM_PINS);  // First step wraps to channel 1
      valid_d   <= 1'b0;
      chan_d    <= '0;
    end else begin
      sel_valid <= 1'b1;
      sel_chan  <= (sel_chan == 8'(`PIN_NUM_PINS)) ? 8'd1 : sel_chan + 8'd1;
      valid_d   <= sel_valid;
      chan_d    <= sel_chan;
    end
  end

  // Only the selected channel drives a non-zero word
  always_comb begin
    word_or = '0;
    for (int i = 1; i <= `PIN_NUM_PINS; i++)
      word_or = word_or | chan_words[i];
  end

  assign new_sample = valid_d && (word_or[31:16] != last_cnt[chan_d]);

  always_ff @(posedge clk) begin
    if (reset) begin
      sample_valid <= 1'b0;
      for (int i = 1; i <= `PIN_NUM_PINS; i++)
        last_cnt[i] <= '0;
    end else begin
      sample_valid <= new_sample;
      if (new_sample)
        last_cnt[chan_d] <= word_or[31:16];
    end
  end

  always_ff @(posedge clk) begin
    if (new_sample) begin
      sample_chan <= chan_d;
      sample_word <= word_or;
    end
  end

endmodule

// File: hw/time_base.sv
`timescale 1ns/100ps
`include "pin_ctrl_config.svh"

module time_base
  import pin_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  cmd_bus_if.sink     bus,
  output logic [31:0] current_time
);

  glob_cmd_t gcmd;     // Holds a written command for one cycle
  logic      running;
  logic      addressed;

  assign addressed = (bus.addr[`PIN_ADDR_W-1:8] == 8'd0);

  // Global command register, clears itself the cycle after a write
  always_ff @(posedge clk) begin
    if (reset) begin
      gcmd <= gcmd_none;
    end else if (bus.wr && addressed && (reg_addr_t'(bus.addr[7:0]) == a_global_cmd)) begin
      if (bus.wdata[31:2] == '0)
        gcmd <= glob_cmd_t'(bus.wdata[1:0]);
      else
        gcmd <= gcmd_none;
    end else begin
      gcmd <= gcmd_none;
    end
  end

  // ----------------------------------------
  // Time counter
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      running      <= 1'b0;
      current_time <= '0;
    end else begin
      case (gcmd)
        gcmd_start: begin
          running      <= 1'b1;
          current_time <= current_time + 32'd1;  // From zero this gives 1
        end
        gcmd_stop:  running <= 1'b0;
        gcmd_clear: current_time <= '0;
        default: begin
          if (running)
            current_time <= current_time + 32'd1;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      bus.rdata <= '0;
    end else if (bus.rd && addressed) begin
      case (reg_addr_t'(bus.addr[7:0]))
        a_time_lo: bus.rdata <= current_time[15:0];
        a_time_hi: bus.rdata <= current_time[31:16];
        default:   bus.rdata <= '0;
      endcase
    end else begin
      bus.rdata <= '0;
    end
  end

endmodule

// File: pin_channel/pin_channel.sv
`timescale 1ns/100ps
`include "pin_ctrl_config.svh"

module pin_channel
  import pin_ctrl_pkg::*;
#(
  parameter int POSITION = 1  // Block number on the command bus
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] current_time,
  cmd_bus_if.sink     bus,
  inout  wire         pin,
  input  logic        sel_valid,
  input  logic [7:0]  sel_chan,
  output logic [31:0] sample_word
);

  logic [31:0] nco_inc;
  logic [31:0] end_time;
  logic [31:0] sample_rate;
  logic [31:0] last_data;    // Last word written to this channel
  logic [31:0] rate_cnt;
  logic [31:0] phase;        // NCO phase accumulator
  pin_cmd_t    cmd_reg;
  logic        cmd_clr;      // Self-clear of the one-shot command
  chan_state_t state;
  logic        sample_reg;
  logic [15:0] sample_cnt;

  logic addressed;
  logic wr_hit;
  logic rd_hit;
  logic start_ok;
  logic sample_tick;
  logic pin_oe;
  logic pin_out;

  assign addressed = (bus.addr[`PIN_ADDR_W-1:8] == 8'(POSITION));
  assign wr_hit    = bus.wr && addressed;
  assign rd_hit    = bus.rd && addressed;

  // Idle picks up a waiting command only once time is running
  assign start_ok    = (state == st_idle) && (current_time != 32'd0) && !cmd_clr;
  assign sample_tick = (state == st_stream) && (rate_cnt <= 32'd1);

  // Unknown command values are ignored
  function automatic pin_cmd_t decode_cmd(input logic [31:0] data);
    case (data)
      32'd2:   return cmd_const;
      32'd3:   return cmd_square;
      32'd4:   return cmd_stream;
      32'd5:   return cmd_reset;
      default: return cmd_none;
    endcase
  endfunction

  // ----------------------------------------
  // Register writes
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      nco_inc     <= '0;
      end_time    <= '0;
      sample_rate <= '0;
      last_data   <= '0;
    end else if (wr_hit) begin
      last_data <= bus.wdata;
      case (reg_addr_t'(bus.addr[7:0]))
        a_nco_inc:     nco_inc <= bus.wdata;
        a_end_time:    end_time <= bus.wdata;
        a_sample_rate: sample_rate <= bus.wdata;
        default:       ;
      endcase
    end
  end

  // A fresh write wins over a pending self-clear
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_reg <= cmd_none;
    end else if (wr_hit && (reg_addr_t'(bus.addr[7:0]) == a_local_cmd)) begin
      cmd_reg <= decode_cmd(bus.wdata);
    end else if (cmd_clr) begin
      cmd_reg <= cmd_none;
    end
  end

  // ----------------------------------------
  // Sequencer
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= st_idle;
      cmd_clr <= 1'b0;
    end else begin
      cmd_clr <= 1'b0;
      case (state)
        st_idle: begin
          if (start_ok && (cmd_reg != cmd_none)) begin
            cmd_clr <= 1'b1;  // Every command is one-shot
            case (cmd_reg)
              cmd_const:  state <= st_const;
              cmd_square: state <= st_square;
              cmd_stream: state <= st_stream;
              default:    state <= st_idle;
            endcase
          end
        end
        st_const: begin
          if (cmd_reg == cmd_reset) begin
            state   <= st_idle;
            cmd_clr <= 1'b1;
          end else if (current_time >= end_time) begin
            state <= st_idle;
          end
        end
        st_square: begin
          if (cmd_reg == cmd_reset) begin
            state   <= st_idle;
            cmd_clr <= 1'b1;
          end else if ((end_time != 32'd0) && (current_time >= end_time)) begin
            state <= st_idle;  // Zero end time means run forever
          end
        end
        st_stream: begin
          if (cmd_reg == cmd_reset) begin
            state   <= st_idle;
            cmd_clr <= 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ----------------------------------------
  // NCO and sample rate counter
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (start_ok && (cmd_reg == cmd_square))
      phase <= '0;
    else if (state == st_square)
      phase <= phase + nco_inc;  // Pin toggles every 2^31 / nco_inc cycles

    if ((start_ok && (cmd_reg == cmd_stream)) || sample_tick)
      rate_cnt <= sample_rate;
    else if (state == st_stream)
      rate_cnt <= rate_cnt - 32'd1;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sample_reg <= 1'b0;
      sample_cnt <= '0;
    end else if (sample_tick) begin
      sample_reg <= pin;
      sample_cnt <= sample_cnt + 16'd1;
    end
  end

  // The pin is released outside the output states
  assign pin_oe  = (state == st_const) || (state == st_square);
  assign pin_out = (state == st_const) ? 1'b1 : phase[31];
  assign pin     = pin_oe ? pin_out : 1'bz;

  // ----------------------------------------
  // Read data and sample word
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      bus.rdata <= '0;
    end else if (rd_hit) begin
      case (reg_addr_t'(bus.addr[7:0]))
        a_sample_reg: bus.rdata <= {15'b0, sample_reg};
        a_sample_cnt: bus.rdata <= sample_cnt;
        a_status:     bus.rdata <= 16'(POSITION);
        a_last_data:  bus.rdata <= last_data[15:0];
        default:      bus.rdata <= '0;
      endcase
    end else begin
      bus.rdata <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset)
      sample_word <= '0;
    else if (sel_valid && (sel_chan == 8'(POSITION)))
      sample_word <= {sample_cnt, `PIN_SAMPLE_TAG, sample_reg};
    else
      sample_word <= '0;  // Zero lets the collector OR all channels
  end

endmodule

// File: common/cmd_bus_if.sv
`timescale 1ns/100ps
`include "pin_ctrl_config.svh"

// Registered command bus from the fabric to one block.
// Each block returns its own read data, zero when it is not answering
interface cmd_bus_if;

  logic                    wr;     // Write strobe, one cycle
  logic                    rd;     // Read strobe, one cycle
  logic [`PIN_ADDR_W-1:0]  addr;   // {block, register}
  logic [`PIN_WDATA_W-1:0] wdata;
  logic [`PIN_RDATA_W-1:0] rdata;  // Registered in the block

  // Fabric side
  modport source (
    output wr,
    output rd,
    output addr,
    output wdata,
    input  rdata
  );

  // Block side
  modport sink (
    input  wr,
    input  rd,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

// File: common/pin_ctrl_pkg.sv
package pin_ctrl_pkg;

  // ----------------------------------------
  // Channel sequencer states
  // ----------------------------------------
  typedef enum logic [1:0] {
    st_idle   = 2'd0,
    st_const  = 2'd1,  // Pin held at 1 until end time
    st_square = 2'd2,  // Pin follows NCO phase MSB
    st_stream = 2'd3   // Pin sampled at the programmed rate
  } chan_state_t;

  // One-shot commands written to a channel's command register
  typedef enum logic [2:0] {
    cmd_none   = 3'd0,
    cmd_const  = 3'd2,
    cmd_square = 3'd3,
    cmd_stream = 3'd4,
    cmd_reset  = 3'd5
  } pin_cmd_t;

  // Commands to the time base at block 0
  typedef enum logic [1:0] {
    gcmd_none  = 2'd0,
    gcmd_start = 2'd1,
    gcmd_stop  = 2'd2,
    gcmd_clear = 2'd3
  } glob_cmd_t;

  // Register map, low address byte
  typedef enum logic [7:0] {
    a_global_cmd  = 8'd0,
    a_nco_inc     = 8'd1,
    a_end_time    = 8'd2,
    a_local_cmd   = 8'd3,
    a_sample_rate = 8'd4,
    a_sample_reg  = 8'd5,
    a_sample_cnt  = 8'd7,
    a_status      = 8'd8,
    a_last_data   = 8'd9,
    a_time_lo     = 8'd10,
    a_time_hi     = 8'd11
  } reg_addr_t;

endpackage

// File: common/pin_ctrl_config.svh
`ifndef PIN_CTRL_CONFIG_SVH
`define PIN_CTRL_CONFIG_SVH

// ----------------------------------------
// Build-time sizing of the controller
// ----------------------------------------

// Number of pin channels, valid range is 1 to 8
`define PIN_NUM_PINS 4

// Host command bus widths
`define PIN_ADDR_W 16   // High byte selects a block, low byte a register
`define PIN_WDATA_W 32
`define PIN_RDATA_W 16

// Framing constant that sits between count and value in a sample word
`define PIN_SAMPLE_TAG {12'hABC, 3'b111}

`endif
